//--- files.f
hdl/rx_link_pkg.sv
hdl/rx_frame_parser.sv
hdl/rx_word_packer.sv
hdl/rx_data_fifo.sv
hdl/rx_dma_cmd.sv
hdl/rx_link_monitor.sv
hdl/rx_link_top.sv
sim/tb_clock_gen.sv
sim/rx_link_assertions.sv
sim/tb_rx_link.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rx_link \
    -f files.f -o tb_rx_link_sim
./obj_dir/tb_rx_link_sim | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- sim/tb_rx_link.sv
`timescale 1ns/1ps
// Receive link testbench
// Random frames with sync idles and garbage in between, checked
// against a queue model of header results, DMA commands and 64-bit
// data words, followed by a link-loss phase

module tb_rx_link import rx_link_pkg::*; ();

    localparam int NUM_FRAMES      = 40;
    localparam int MAX_FRAME_WORDS = 42;
    localparam int MAX_GAP         = 10;
    localparam int TIMEOUT_CYCLES  =
        NUM_FRAMES * (MAX_FRAME_WORDS + MAX_GAP) * 4 + 4 * LINK_HOLDOFF;

    logic              clk;
    logic              rst;
    lane_word_t        lane;
    logic              rx_start;
    logic [ADDR_W-1:0] base_addr;
    logic              loss_en;
    logic              cmd_valid;
    dma_cmd_t          cmd;
    logic              cmd_ready;
    logic              wr_valid;
    logic [DMA_W-1:0]  wr_data;
    logic              wr_ready;
    logic              frame_done;
    frame_info_t       info;
    logic              fifo_ovf;
    logic              link_loss;

    // Expected results, oldest first
    frame_info_t       info_q[$];
    dma_cmd_t          cmd_q[$];
    logic [DMA_W-1:0]  data_q[$];
    logic [ADDR_W-1:0] next_addr;
    int                loss_count = 0;
    int                cycle_cnt = 0;

    tb_clock_gen u_clk_gen (.clk(clk), .o_rst(rst));

    rx_link_top uut (
        .clk(clk), .i_rst(rst), .i_lane(lane),
        .i_rx_start(rx_start), .i_base_addr(base_addr), .i_loss_detect_en(loss_en),
        .o_cmd_valid(cmd_valid), .o_cmd(cmd), .i_cmd_ready(cmd_ready),
        .o_wr_valid(wr_valid), .o_wr_data(wr_data), .i_wr_ready(wr_ready),
        .o_frame_done(frame_done), .o_info(info),
        .o_fifo_overflow(fifo_ovf), .o_link_loss(link_loss)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h",
                                name, actual, expected));
        end
    endtask

    // One link word per cycle, held until the next edge
    task automatic drive_word(input logic k_msb, input logic k_lsb, input logic [15:0] data);
        lane.k_msb = k_msb;
        lane.k_lsb = k_lsb;
        lane.data  = data;
        @(posedge clk);
        #1;
    endtask

    task automatic send_idle(input int n);
        repeat (n) drive_word(1'b0, 1'b1, SYNC_WORD);
    endtask

    task automatic send_garbage(input int n);
        repeat (n) drive_word(1'b0, 1'b0, 16'($urandom));
    endtask

    task automatic pulse_start(input logic [ADDR_W-1:0] base);
        rx_start  = 1'b1;
        base_addr = base;
        next_addr = base;
        drive_word(1'b0, 1'b1, SYNC_WORD);
        rx_start  = 1'b0;
    endtask

    task automatic send_frame(input bit bad_head, input bit bad_csum);
        frame_info_t      exp;
        dma_cmd_t         exp_cmd;
        logic [15:0]      payload[$];
        logic [15:0]      hdr_w[3];
        logic [15:0]      sum;
        logic [15:0]      flag_lo;
        logic [DMA_W-1:0] beat;
        int               n_words;

        exp.file_end  = 1'($urandom_range(0, 1));
        exp.channel   = 2'($urandom_range(0, 3));
        exp.data_type = 4'($urandom_range(0, 15));
        exp.line_num  = 24'($urandom);
        exp.byte_len  = 16'(2 * $urandom_range(1, 32));
        exp.csum_err  = bad_csum;
        n_words       = int'(exp.byte_len) / 2;
        // Type word holds file end, channel, data type and top line bits
        hdr_w[0] = {1'b0, exp.file_end, exp.channel, exp.data_type, exp.line_num[23:16]};
        hdr_w[1] = exp.line_num[15:0];
        hdr_w[2] = exp.byte_len;
        sum = hdr_w[0] + hdr_w[1] + hdr_w[2];
        for (int i = 0; i < n_words; i++) begin
            payload.push_back(16'($urandom));
            sum = sum + payload[i];
        end
        if (bad_csum) begin
            sum = sum ^ (16'd1 << $urandom_range(0, 15));
        end
        if (!bad_head) begin
            info_q.push_back(exp);
            exp_cmd.addr     = next_addr;
            exp_cmd.byte_cnt = (exp.byte_len + 16'd7) & ~16'd7;
            cmd_q.push_back(exp_cmd);
            next_addr = next_addr + ADDR_W'(exp_cmd.byte_cnt);
            // First payload word in the low lane, unused lanes zero
            for (int b = 0; b < (n_words + 3) / 4; b++) begin
                beat = '0;
                for (int l = 0; l < 4; l++) begin
                    if (4 * b + l < n_words) begin
                        beat[16 * l +: 16] = payload[4 * b + l];
                    end
                end
                data_q.push_back(beat);
            end
        end
        flag_lo = HEAD_FLAG[15:0] ^ (bad_head ? 16'(1 << $urandom_range(0, 15)) : 16'h0);
        send_idle($urandom_range(1, 3));
        drive_word(1'b1, 1'b1, SOF_WORD);
        drive_word(1'b0, 1'b0, HEAD_FLAG[31:16]);
        drive_word(1'b0, 1'b0, flag_lo);
        foreach (hdr_w[i]) drive_word(1'b0, 1'b0, hdr_w[i]);
        foreach (payload[i]) drive_word(1'b0, 1'b0, payload[i]);
        drive_word(1'b0, 1'b0, sum);
        // Two words pass through END1 and END2
        send_idle(2);
        send_garbage($urandom_range(0, MAX_GAP - 2));
    endtask

    // Outputs sampled at the falling edge, handshakes complete at the next rise
    always @(negedge clk) begin
        if (!rst) begin
            if (frame_done) begin
                if (info_q.size() == 0) begin
                    abort_run("frame_done pulsed with no frame outstanding");
                end else begin
                    check_equal("o_info", 64'(info), 64'(info_q.pop_front()));
                end
            end
            if (cmd_valid && cmd_ready) begin
                if (cmd_q.size() == 0) begin
                    abort_run("DMA command issued with no frame outstanding");
                end else begin
                    check_equal("o_cmd", 64'(cmd), 64'(cmd_q.pop_front()));
                end
            end
            if (wr_valid && wr_ready) begin
                if (data_q.size() == 0) begin
                    abort_run("DMA data word written with no data outstanding");
                end else begin
                    check_equal("o_wr_data", wr_data, data_q.pop_front());
                end
            end
            if (link_loss) begin
                loss_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles with results still missing",
                                TIMEOUT_CYCLES));
        end
    end

    // Random back-pressure on both DMA ports
    initial begin
        cmd_ready = 1'b0;
        wr_ready  = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            cmd_ready = ($urandom_range(0, 3) != 0);
            wr_ready  = ($urandom_range(0, 1) == 1);
        end
    end

    initial begin
        int gap;
        int gap_sum;
        void'($urandom(32'h321d));
        lane      = '{k_msb: 1'b0, k_lsb: 1'b0, data: 16'h0000};
        rx_start  = 1'b0;
        base_addr = '0;
        loss_en   = 1'b0;
        next_addr = '0;
        wait (rst == 1'b0);
        @(posedge clk);
        #1;
        loss_en = 1'b1;
        send_garbage(8);
        pulse_start(ADDR_W'($urandom));
        for (int i = 0; i < NUM_FRAMES; i++) begin
            send_frame(i % 9 == 4, i % 5 == 2);
            if (i == NUM_FRAMES / 2) begin
                pulse_start(ADDR_W'($urandom));
            end
        end
        send_idle(4);
        while (info_q.size() != 0 || cmd_q.size() != 0 || data_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        check_equal("o_link_loss count", loss_count, 0);

        // One report, repeats up to the last cycle of the hold-off ignored
        drive_word(1'b1, 1'b1, LOSS_WORD);
        send_idle(3);
        check_equal("o_link_loss count", loss_count, 1);
        gap_sum = 3;
        repeat (5) begin
            gap = $urandom_range(10, 100);
            send_idle(gap);
            drive_word(1'b1, 1'b1, LOSS_WORD);
            gap_sum = gap_sum + gap + 1;
        end
        send_idle(LINK_HOLDOFF - 1 - gap_sum);
        drive_word(1'b1, 1'b1, LOSS_WORD);
        send_idle(1);
        check_equal("o_link_loss count", loss_count, 1);
        // Window over, reported again
        drive_word(1'b1, 1'b1, LOSS_WORD);
        send_idle(3);
        check_equal("o_link_loss count", loss_count, 2);
        loss_en = 1'b0;
        repeat (3) begin
            send_idle(5);
            drive_word(1'b1, 1'b1, LOSS_WORD);
        end
        send_idle(4);
        check_equal("o_link_loss count", loss_count, 2);
        check_equal("o_fifo_overflow", fifo_ovf, 1'b0);

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- sim/rx_link_assertions.sv
`timescale 1ns/1ps
// Receive link assertions
// Handshake stability, single-cycle pulses and idle outputs after reset

module rx_link_assertions import rx_link_pkg::*; (
    input logic             clk,
    input logic             i_rst,
    input logic             i_cmd_valid,
    input dma_cmd_t         i_cmd,
    input logic             i_cmd_ready,
    input logic             i_wr_valid,
    input logic [DMA_W-1:0] i_wr_data,
    input logic             i_wr_ready,
    input logic             i_frame_done,
    input logic             i_link_loss,
    input logic             i_fifo_overflow
);

    cmd_hold: assert property (@(posedge clk) disable iff (i_rst)
        i_cmd_valid && !i_cmd_ready |=> i_cmd_valid && $stable(i_cmd))
        else $error("DMA command changed or dropped before it was accepted");

    wr_hold: assert property (@(posedge clk) disable iff (i_rst)
        i_wr_valid && !i_wr_ready |=> i_wr_valid && $stable(i_wr_data))
        else $error("DMA data changed or dropped before it was accepted");

    done_pulse: assert property (@(posedge clk) disable iff (i_rst)
        i_frame_done |=> !i_frame_done)
        else $error("frame_done held high for more than one cycle");

    loss_pulse: assert property (@(posedge clk) disable iff (i_rst)
        i_link_loss |=> !i_link_loss)
        else $error("link_loss held high for more than one cycle");

    // Nothing valid once reset has been applied
    reset_idle: assert property (@(posedge clk)
        i_rst |=> !i_cmd_valid && !i_wr_valid && !i_frame_done
                  && !i_link_loss && !i_fifo_overflow)
        else $error("output active right after reset");

endmodule

bind rx_link_top rx_link_assertions u_assertions (
    .clk(clk), .i_rst(i_rst),
    .i_cmd_valid(o_cmd_valid), .i_cmd(o_cmd), .i_cmd_ready(i_cmd_ready),
    .i_wr_valid(o_wr_valid), .i_wr_data(o_wr_data), .i_wr_ready(i_wr_ready),
    .i_frame_done(o_frame_done), .i_link_loss(o_link_loss),
    .i_fifo_overflow(o_fifo_overflow)
);

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
// Testbench clock and reset
// 10 ns clock, reset held high for the first 5 cycles

module tb_clock_gen (
    output logic clk,
    output logic o_rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        o_rst = 1'b0;
    end

endmodule

//--- hdl/rx_link_top.sv
`timescale 1ns/1ps
// Receive link top level
// Parser, word packer, data FIFO, DMA command generator and
// link-loss monitor along the 16-bit serial receive path

module rx_link_top import rx_link_pkg::*; (
    input  logic              clk,
    input  logic              i_rst,
    input  lane_word_t        i_lane,
    input  logic              i_rx_start,
    input  logic [ADDR_W-1:0] i_base_addr,
    input  logic              i_loss_detect_en,
    output logic              o_cmd_valid,
    output dma_cmd_t          o_cmd,
    input  logic              i_cmd_ready,
    output logic              o_wr_valid,
    output logic [DMA_W-1:0]  o_wr_data,
    input  logic              i_wr_ready,
    output logic              o_frame_done,
    output frame_info_t       o_info,
    output logic              o_fifo_overflow,
    output logic              o_link_loss
);

    logic               word_valid;
    logic [15:0]        word;
    logic               len_valid;
    logic [BYTES_W-1:0] len;
    logic               frame_end;
    logic               fifo_wr_en;
    logic [DMA_W-1:0]   fifo_wr_data;

    rx_frame_parser u_parser (
        .clk(clk), .i_rst(i_rst), .i_lane(i_lane),
        .o_word_valid(word_valid), .o_word(word),
        .o_len_valid(len_valid), .o_len(len),
        .o_frame_end(frame_end),
        .o_frame_done(o_frame_done), .o_info(o_info)
    );

    rx_word_packer u_packer (
        .clk(clk), .i_rst(i_rst),
        .i_word_valid(word_valid), .i_word(word), .i_frame_end(frame_end),
        .o_wr_en(fifo_wr_en), .o_wr_data(fifo_wr_data)
    );

    rx_data_fifo u_fifo (
        .clk(clk), .i_rst(i_rst),
        .i_wr_en(fifo_wr_en), .i_wr_data(fifo_wr_data),
        .o_rd_valid(o_wr_valid), .o_rd_data(o_wr_data), .i_rd_ready(i_wr_ready),
        .o_overflow(o_fifo_overflow)
    );

    rx_dma_cmd u_dma_cmd (
        .clk(clk), .i_rst(i_rst),
        .i_rx_start(i_rx_start), .i_base_addr(i_base_addr),
        .i_len_valid(len_valid), .i_len(len), .i_frame_end(frame_end),
        .o_cmd_valid(o_cmd_valid), .o_cmd(o_cmd), .i_cmd_ready(i_cmd_ready)
    );

    rx_link_monitor u_monitor (
        .clk(clk), .i_rst(i_rst), .i_lane(i_lane),
        .i_detect_en(i_loss_detect_en), .o_link_loss(o_link_loss)
    );

endmodule

//--- hdl/rx_link_monitor.sv
`timescale 1ns/1ps
// Link-loss monitor
// Reports a loss word with a single pulse, then ignores further
// loss words for a hold-off window of LINK_HOLDOFF cycles

module rx_link_monitor import rx_link_pkg::*; (
    input  logic       clk,
    input  logic       i_rst,
    input  lane_word_t i_lane,
    input  logic       i_detect_en,
    output logic       o_link_loss
);

    logic                 is_loss;
    logic                 holdoff;
    logic [HOLDOFF_W-1:0] hold_cnt;

    assign is_loss = i_lane.k_msb & i_lane.k_lsb & (i_lane.data == LOSS_WORD);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_link_loss <= 1'b0;
            holdoff     <= 1'b0;
            hold_cnt    <= '0;
        end else if (!i_detect_en) begin
            // Disabling detection also ends any hold-off
            o_link_loss <= 1'b0;
            holdoff     <= 1'b0;
            hold_cnt    <= '0;
        end else begin
            o_link_loss <= is_loss & ~holdoff;
            if (is_loss & ~holdoff) begin
                holdoff  <= 1'b1;
                hold_cnt <= '0;
            end else if (holdoff) begin
                if (hold_cnt == HOLDOFF_W'(LINK_HOLDOFF - 1)) begin
                    holdoff <= 1'b0;
                end
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

endmodule

//--- hdl/rx_dma_cmd.sv
`timescale 1ns/1ps
// DMA write command generator
// Issues one write command per frame with the running address and
// the byte length rounded up to 8, then steps the address forward

module rx_dma_cmd import rx_link_pkg::*; (
    input  logic               clk,
    input  logic               i_rst,
    input  logic               i_rx_start,
    input  logic [ADDR_W-1:0]  i_base_addr,
    input  logic               i_len_valid,
    input  logic [BYTES_W-1:0] i_len,
    input  logic               i_frame_end,
    output logic               o_cmd_valid,
    output dma_cmd_t           o_cmd,
    input  logic               i_cmd_ready
);

    logic [ADDR_W-1:0]  addr;
    logic [BYTES_W-1:0] len_round;
    logic [BYTES_W-1:0] step;

    // DDR writes go in 8-byte units
    assign len_round = {i_len[BYTES_W-1:3] + {{(BYTES_W-4){1'b0}}, |i_len[2:0]}, 3'b000};

    always_ff @(posedge clk) begin
        if (i_rst) begin
            addr        <= '0;
            step        <= '0;
            o_cmd_valid <= 1'b0;
        end else begin
            if (i_len_valid) begin
                o_cmd_valid <= 1'b1;
                step        <= len_round;
            end else if (i_cmd_ready) begin
                o_cmd_valid <= 1'b0;
            end
            // Host start wins over the per-frame advance
            if (i_rx_start) begin
                addr <= i_base_addr;
            end else if (i_frame_end) begin
                addr <= addr + ADDR_W'(step);
            end
        end
    end

    // Command frozen at the length word so it holds while pending
    always_ff @(posedge clk) begin
        if (i_len_valid) begin
            o_cmd <= '{addr: addr, byte_cnt: len_round};
        end
    end

endmodule

//--- hdl/rx_data_fifo.sv
`timescale 1ns/1ps
// Receive data FIFO
// Show-ahead buffer of 64-bit words toward the DMA write stream.
// The link cannot be stalled, so a write into a full FIFO is
// dropped and a sticky overflow flag is raised

module rx_data_fifo import rx_link_pkg::*; (
    input  logic             clk,
    input  logic             i_rst,
    input  logic             i_wr_en,
    input  logic [DMA_W-1:0] i_wr_data,
    output logic             o_rd_valid,
    output logic [DMA_W-1:0] o_rd_data,
    input  logic             i_rd_ready,
    output logic             o_overflow
);

    logic [DMA_W-1:0]   mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               push;
    logic               pop;

    assign full       = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign push       = i_wr_en & ~full;
    assign pop        = o_rd_valid & i_rd_ready;
    // Head word shown whenever not empty
    assign o_rd_valid = (count != '0);
    assign o_rd_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (i_wr_en & full) begin
                o_overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

endmodule

//--- hdl/rx_word_packer.sv
`timescale 1ns/1ps
// Payload word packer
// Collects four 16-bit payload words into one 64-bit DMA word,
// first word in the low lane, and flushes a zero-padded partial
// word at the end of each frame

module rx_word_packer import rx_link_pkg::*; (
    input  logic             clk,
    input  logic             i_rst,
    input  logic             i_word_valid,
    input  logic [15:0]      i_word,
    input  logic             i_frame_end,
    output logic             o_wr_en,
    output logic [DMA_W-1:0] o_wr_data
);

    logic [1:0]       lane;
    logic [DMA_W-1:0] pack;
    logic [DMA_W-1:0] fill_mask;

    // Keeps only the lanes already filled
    always_comb begin
        case (lane)
            2'd1:    fill_mask = 64'h0000_0000_0000_FFFF;
            2'd2:    fill_mask = 64'h0000_0000_FFFF_FFFF;
            2'd3:    fill_mask = 64'h0000_FFFF_FFFF_FFFF;
            default: fill_mask = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Lane position and write strobe
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_rst) begin
            lane    <= 2'd0;
            o_wr_en <= 1'b0;
        end else begin
            o_wr_en <= 1'b0;
            if (i_word_valid) begin
                lane    <= lane + 2'd1;
                o_wr_en <= (lane == 2'd3);
            end else if (i_frame_end) begin
                // Flush only when something is left over
                lane    <= 2'd0;
                o_wr_en <= (lane != 2'd0);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Word assembly
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_word_valid) begin
            pack[{lane, 4'b0000} +: 16] <= i_word;
            // Fourth word completes the beat directly
            o_wr_data <= {i_word, pack[DMA_W-17:0]};
        end else if (i_frame_end) begin
            o_wr_data <= pack & fill_mask;
        end
    end

endmodule

//--- hdl/rx_frame_parser.sv
`timescale 1ns/1ps
// Receive frame parser
// Finds sync, start-of-frame and the 32-bit head flag, captures
// the type, line and length words, strobes the payload words out
// and checks the 16-bit running checksum at the end of the frame

module rx_frame_parser import rx_link_pkg::*; (
    input  logic               clk,
    input  logic               i_rst,
    input  lane_word_t         i_lane,
    output logic               o_word_valid,
    output logic [15:0]        o_word,
    output logic               o_len_valid,
    output logic [BYTES_W-1:0] o_len,
    output logic               o_frame_end,
    output logic               o_frame_done,
    output frame_info_t        o_info
);

    rx_state_e          state;
    rx_state_e          state_nxt;
    logic [15:0]        prev_data;
    logic               head_half;
    logic [BYTES_W-2:0] data_cnt;
    logic [15:0]        csum;
    frame_info_t        hdr;
    logic               is_sync;
    logic               is_sof;
    logic               last_data;

    assign is_sync   = ~i_lane.k_msb & i_lane.k_lsb & (i_lane.data == SYNC_WORD);
    assign is_sof    = i_lane.k_msb & i_lane.k_lsb & (i_lane.data == SOF_WORD);
    // Length is in bytes, two bytes per link word
    assign last_data = (data_cnt == hdr.byte_len[BYTES_W-1:1] - 1'b1);

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (is_sync) begin
                    state_nxt = SYNC;
                end
            end
            SYNC: begin
                // Repeated sync idles keep us waiting for SOF
                if (is_sof) begin
                    state_nxt = HEAD;
                end else if (!is_sync) begin
                    state_nxt = IDLE;
                end
            end
            HEAD: begin
                // Second flag word: compare the full 32 bits
                if (head_half) begin
                    if ({prev_data, i_lane.data} == HEAD_FLAG) begin
                        state_nxt = TYPE;
                    end else begin
                        state_nxt = IDLE;
                    end
                end
            end
            TYPE:   state_nxt = LINE;
            LINE:   state_nxt = LENGTH;
            LENGTH: state_nxt = DATA;
            DATA: begin
                if (last_data) begin
                    state_nxt = CHECK;
                end
            end
            CHECK:   state_nxt = END1;
            END1:    state_nxt = END2;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state        <= IDLE;
            head_half    <= 1'b0;
            data_cnt     <= '0;
            o_word_valid <= 1'b0;
            o_len_valid  <= 1'b0;
            o_frame_end  <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            state        <= state_nxt;
            head_half    <= (state == HEAD) & ~head_half;
            data_cnt     <= (state == DATA) ? data_cnt + 1'b1 : '0;
            o_word_valid <= (state == DATA);
            o_len_valid  <= (state == LENGTH);
            o_frame_end  <= (state == END1);
            o_frame_done <= (state == CHECK);
        end
    end

    ////////////////////////////////////////////////////////////
    // Header capture and checksum
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        prev_data <= i_lane.data;
        o_word    <= i_lane.data;
        o_len     <= i_lane.data;

        case (state)
            TYPE: begin
                hdr.file_end            <= i_lane.data[14];
                hdr.channel             <= i_lane.data[13:12];
                hdr.data_type           <= i_lane.data[11:8];
                hdr.line_num[23:16]     <= i_lane.data[7:0];
                hdr.csum_err            <= 1'b0;
            end
            LINE:   hdr.line_num[15:0] <= i_lane.data;
            LENGTH: hdr.byte_len       <= i_lane.data;
            CHECK: begin
                // Result held until the next frame completes
                o_info          <= hdr;
                o_info.csum_err <= (csum != i_lane.data);
            end
            default: ;
        endcase

        // Sum covers type word through the last payload word
        if (state inside {TYPE, LINE, LENGTH, DATA}) begin
            csum <= csum + i_lane.data;
        end else begin
            csum <= '0;
        end
    end

endmodule

//--- hdl/rx_link_pkg.sv
// Receive link package
// Link codes, sizes, parser states and the structs that are
// shared along the 16-bit link receive path

package rx_link_pkg;

    ////////////////////////////////////////////////////////////
    // Link codes
    ////////////////////////////////////////////////////////////

    // D5.6 high byte, K28.5 low byte
    localparam logic [15:0] SYNC_WORD = 16'hC5BC;
    // K28.2 high byte, K27.7 low byte
    localparam logic [15:0] SOF_WORD  = 16'h5CFB;
    localparam logic [31:0] HEAD_FLAG = 32'hEB90_E116;
    // Sent with both K flags when the link drops
    localparam logic [15:0] LOSS_WORD = 16'hFFFF;

    ////////////////////////////////////////////////////////////
    // Sizes and limits
    ////////////////////////////////////////////////////////////

    localparam int ADDR_W       = 32;
    localparam int BYTES_W      = 16;
    localparam int DMA_W        = 64;
    localparam int FIFO_DEPTH   = 512;
    localparam int FIFO_AW      = $clog2(FIFO_DEPTH);
    localparam int LINK_HOLDOFF = 1024;
    localparam int HOLDOFF_W    = $clog2(LINK_HOLDOFF);

    // Parser states, one link word per cycle
    typedef enum logic [3:0] {
        IDLE, SYNC, HEAD, TYPE, LINE, LENGTH, DATA, CHECK, END1, END2
    } rx_state_e;

    typedef struct packed {
        logic        k_msb;
        logic        k_lsb;
        logic [15:0] data;
    } lane_word_t;

    // Type word layout: [14] file end, [13:12] channel,
    // [11:8] data type, [7:0] line number bits 23..16
    typedef struct packed {
        logic               file_end;
        logic [1:0]         channel;
        logic [3:0]         data_type;
        logic [23:0]        line_num;
        logic [BYTES_W-1:0] byte_len;
        logic               csum_err;
    } frame_info_t;

    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [BYTES_W-1:0] byte_cnt;
    } dma_cmd_t;

endpackage
